// ==== msr_pkg.sv ====
//****************************************
// Widths, MSR addresses, op codes, PSR
// fields and the CPUID word
//****************************************
package msr_pkg;

   // Data path and register widths
   localparam int DATA_W = 32;
   localparam int PSR_W  = 10;
   localparam int ADDR_W = 3;
   localparam int OP_W   = 2;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [PSR_W-1:0]  psr_t;
   typedef logic [ADDR_W-1:0] msr_addr_t;
   typedef logic [OP_W-1:0]   msr_op_t;

   // MSR address map, 6 and 7 are unused
   localparam msr_addr_t MSR_PSR    = 3'd0;
   localparam msr_addr_t MSR_CPUID  = 3'd1;
   localparam msr_addr_t MSR_EPSR   = 3'd2;
   localparam msr_addr_t MSR_EPC    = 3'd3;
   localparam msr_addr_t MSR_ELSA   = 3'd4;
   localparam msr_addr_t MSR_COREID = 3'd5;

   // Request kinds
   localparam msr_op_t OP_READ       = 2'd0;
   localparam msr_op_t OP_WRITE      = 2'd1;
   localparam msr_op_t OP_EXC_ENTER  = 2'd2;
   localparam msr_op_t OP_EXC_RETURN = 2'd3;

   // PSR field positions
   localparam int PSR_CC   = 0;
   localparam int PSR_RM   = 4;
   localparam int PSR_IRE  = 5;
   localparam int PSR_IMME = 6;
   localparam int PSR_DMME = 7;

   localparam psr_t PSR_WMASK = psr_t'((1 << PSR_CC) | (1 << PSR_RM) | (1 << PSR_IRE) |
                                       (1 << PSR_IMME) | (1 << PSR_DMME));
   // Out of reset the core sits in root mode
   localparam psr_t PSR_RESET = psr_t'(1 << PSR_RM);

   // Feature flags from bit 18 up: immu dmmu icache dcache debug fpu irqc tsc
   localparam logic [7:0] CPUID_VER  = 8'd1;
   localparam logic [9:0] CPUID_REV  = 10'd0;
   localparam logic [7:0] CPUID_FEAT = 8'b1100_0001;
   localparam data_t CPUID_VALUE = {6'd0, CPUID_FEAT, CPUID_REV, CPUID_VER};

   // Set while an exception handler runs
   typedef enum logic {
      ST_RUN,
      ST_HANDLER
   } bank_state_t;

endpackage

// ==== msr_req_if.sv ====
//****************************************
// Decoded MSR request, decode to execute
//****************************************
`timescale 1ns/1ps

interface msr_req_if;
   import msr_pkg::*;

   logic      valid;
   logic      ready;
   msr_op_t   op;
   msr_addr_t addr;
   data_t     wdata;
   data_t     pc;
   data_t     lsa;
   // Classified once in decode
   logic      addr_bad;
   logic      ro_hit;

   modport producer (
      output valid, op, addr, wdata, pc, lsa, addr_bad, ro_hit,
      input  ready
   );

   modport consumer (
      input  valid, op, addr, wdata, pc, lsa, addr_bad, ro_hit,
      output ready
   );

endinterface

// ==== msr_decode.sv ====
//****************************************
// Request register and address decode
//****************************************
`timescale 1ns/1ps

module msr_decode (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                req_valid,
   output logic                req_ready,
   input  msr_pkg::msr_op_t    req_op,
   input  msr_pkg::msr_addr_t  req_addr,
   input  msr_pkg::data_t      req_wdata,
   input  msr_pkg::data_t      req_pc,
   input  msr_pkg::data_t      req_lsa,
   msr_req_if.producer         dec
);
   import msr_pkg::*;

   logic req_fire;
   logic is_rw;
   logic bad_nxt;
   logic ro_nxt;

   // Free when empty or drained this cycle
   assign req_ready = !dec.valid || dec.ready;
   assign req_fire  = req_valid && req_ready;

   // Address only matters for reads and writes
   assign is_rw   = (req_op == OP_READ) || (req_op == OP_WRITE);
   assign bad_nxt = is_rw && (req_addr > MSR_COREID);
   assign ro_nxt  = (req_op == OP_WRITE) &&
                    ((req_addr == MSR_CPUID) || (req_addr == MSR_COREID));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dec.valid <= 1'b0;
      end else if (req_fire) begin
         dec.valid <= 1'b1;
      end else if (dec.ready) begin
         dec.valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (req_fire) begin
         dec.op       <= req_op;
         dec.addr     <= req_addr;
         dec.wdata    <= req_wdata;
         dec.pc       <= req_pc;
         dec.lsa      <= req_lsa;
         dec.addr_bad <= bad_nxt;
         dec.ro_hit   <= ro_nxt;
      end
   end

   // A stalled request must not change under the bank
   a_dec_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (dec.valid && !dec.ready) |=>
         (dec.valid && $stable({dec.op, dec.addr, dec.wdata, dec.pc, dec.lsa,
                                dec.addr_bad, dec.ro_hit})));

endmodule

// ==== msr_bank.sv ====
//****************************************
// Execute stage with PSR, EPSR, EPC, ELSA
//****************************************
`timescale 1ns/1ps

module msr_bank #(
   parameter int unsigned CORE_ID = 0
) (
   input  logic            clk,
   input  logic            rst_n,
   msr_req_if.consumer     dec,
   output logic            exe_valid,
   input  logic            exe_ready,
   output msr_pkg::data_t  exe_data,
   output logic            exe_err
);
   import msr_pkg::*;

   psr_t        psr, psr_nxt;
   psr_t        epsr, epsr_nxt;
   data_t       epc, epc_nxt;
   data_t       elsa, elsa_nxt;
   bank_state_t state, state_nxt;
   logic        fire;

   // No storage here, so stall straight through
   assign exe_valid = dec.valid;
   assign dec.ready = exe_ready;
   assign fire      = dec.valid && exe_ready;

   always_comb begin
      psr_nxt   = psr;
      epsr_nxt  = epsr;
      epc_nxt   = epc;
      elsa_nxt  = elsa;
      state_nxt = state;
      exe_data  = '0;
      exe_err   = 1'b0;
      case (dec.op)
         OP_READ: begin
            if (dec.addr_bad) begin
               exe_err = 1'b1;
            end else begin
               case (dec.addr)
                  MSR_PSR:    exe_data = data_t'(psr);
                  MSR_CPUID:  exe_data = CPUID_VALUE;
                  MSR_EPSR:   exe_data = data_t'(epsr);
                  MSR_EPC:    exe_data = epc;
                  MSR_ELSA:   exe_data = elsa;
                  MSR_COREID: exe_data = data_t'(CORE_ID);
                  default:    exe_err  = 1'b1;
               endcase
            end
         end
         OP_WRITE: begin
            if (dec.addr_bad || dec.ro_hit) begin
               exe_err = 1'b1;
            end else begin
               case (dec.addr)
                  MSR_PSR: begin
                     psr_nxt  = dec.wdata[PSR_W-1:0] & PSR_WMASK;
                     exe_data = data_t'(psr_nxt);
                  end
                  MSR_EPSR: begin
                     epsr_nxt = dec.wdata[PSR_W-1:0];
                     exe_data = data_t'(epsr_nxt);
                  end
                  MSR_EPC: begin
                     epc_nxt  = dec.wdata;
                     exe_data = epc_nxt;
                  end
                  MSR_ELSA: begin
                     elsa_nxt = dec.wdata;
                     exe_data = elsa_nxt;
                  end
                  default: exe_err = 1'b1;
               endcase
            end
         end
         OP_EXC_ENTER: begin
            // Save context, then enter root mode with translation off
            epsr_nxt          = psr;
            epc_nxt           = dec.pc;
            elsa_nxt          = dec.lsa;
            psr_nxt[PSR_RM]   = 1'b1;
            psr_nxt[PSR_IRE]  = 1'b0;
            psr_nxt[PSR_IMME] = 1'b0;
            psr_nxt[PSR_DMME] = 1'b0;
            state_nxt         = ST_HANDLER;
            exe_data          = data_t'(psr_nxt);
         end
         default: begin
            if (state == ST_HANDLER) begin
               psr_nxt   = epsr & PSR_WMASK;
               state_nxt = ST_RUN;
               exe_data  = epc;
            end else begin
               // Return with no handler active
               exe_err = 1'b1;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         psr   <= PSR_RESET;
         epsr  <= '0;
         epc   <= '0;
         elsa  <= '0;
         state <= ST_RUN;
      end else if (fire) begin
         psr   <= psr_nxt;
         epsr  <= epsr_nxt;
         epc   <= epc_nxt;
         elsa  <= elsa_nxt;
         state <= state_nxt;
      end
   end

   a_psr_mask: assert property (@(posedge clk) disable iff (!rst_n)
      (psr & ~PSR_WMASK) == '0);

   a_enter_rm: assert property (@(posedge clk) disable iff (!rst_n)
      (fire && dec.op == OP_EXC_ENTER) |=> psr[PSR_RM]);

endmodule

// ==== msr_result.sv ====
//****************************************
// Response register with back-pressure
//****************************************
`timescale 1ns/1ps

module msr_result (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            exe_valid,
   output logic            exe_ready,
   input  msr_pkg::data_t  exe_data,
   input  logic            exe_err,
   output logic            rsp_valid,
   input  logic            rsp_ready,
   output msr_pkg::data_t  rsp_data,
   output logic            rsp_err
);
   import msr_pkg::*;

   data_t data_q;
   logic  err_q;
   logic  exe_fire;

   // Take a new response when empty or being read out
   assign exe_ready = !rsp_valid || rsp_ready;
   assign exe_fire  = exe_valid && exe_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else if (exe_fire) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (exe_fire) begin
         data_q <= exe_data;
         err_q  <= exe_err;
      end
   end

   assign rsp_data = data_q;
   assign rsp_err  = err_q;

   // Held response stays put until the consumer takes it
   a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable({rsp_data, rsp_err})));

endmodule

// ==== msr_unit.sv ====
//****************************************
// MSR unit top, decode/bank/result
//****************************************
`timescale 1ns/1ps

module msr_unit #(
   parameter int unsigned CORE_ID = 0
) (
   input  logic                clk,
   input  logic                rst_n,
   // Request side
   input  logic                req_valid,
   output logic                req_ready,
   input  msr_pkg::msr_op_t    req_op,
   input  msr_pkg::msr_addr_t  req_addr,
   input  msr_pkg::data_t      req_wdata,
   input  msr_pkg::data_t      req_pc,
   input  msr_pkg::data_t      req_lsa,
   // Response side
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output msr_pkg::data_t      rsp_data,
   output logic                rsp_err
);
   import msr_pkg::*;

   logic  exe_valid;
   logic  exe_ready;
   data_t exe_data;
   logic  exe_err;

   msr_req_if i_req_if ();

   msr_decode i_decode (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_op    (req_op),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .req_pc    (req_pc),
      .req_lsa   (req_lsa),
      .dec       (i_req_if.producer)
   );

   msr_bank #(
      .CORE_ID (CORE_ID)
   ) i_bank (
      .clk       (clk),
      .rst_n     (rst_n),
      .dec       (i_req_if.consumer),
      .exe_valid (exe_valid),
      .exe_ready (exe_ready),
      .exe_data  (exe_data),
      .exe_err   (exe_err)
   );

   msr_result i_result (
      .clk       (clk),
      .rst_n     (rst_n),
      .exe_valid (exe_valid),
      .exe_ready (exe_ready),
      .exe_data  (exe_data),
      .exe_err   (exe_err),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data),
      .rsp_err   (rsp_err)
   );

endmodule

// ==== msr_checker.sv ====
//****************************************
// Response checker against golden file
//****************************************
`timescale 1ns/1ps

module msr_checker (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            rsp_valid,
   input  logic            rsp_ready,
   input  msr_pkg::data_t  rsp_data,
   input  logic            rsp_err,
   output int              n_done,
   output int              n_err
);
   import msr_pkg::*;

   string names[$];
   data_t exp_data[$];
   logic  exp_err[$];
   int    done_cnt = 0;
   int    err_cnt = 0;

   assign n_done = done_cnt;
   assign n_err  = err_cnt;

   // Expected columns only, stimulus is driven by the testbench top
   initial begin : load_expected
      int        fd;
      int        cnt;
      string     line;
      string     name;
      msr_op_t   op;
      msr_addr_t addr;
      data_t     wdata, pc, lsa, ed;
      logic      ee;
      fd = $fopen("msr_golden.txt", "r");
      if (fd == 0) begin
         $display("checker cannot open msr_golden.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (cnt > 0 && line.getc(0) != "#") begin
               cnt = $sscanf(line, "%s %h %h %h %h %h %h %h",
                             name, op, addr, wdata, pc, lsa, ed, ee);
               if (cnt == 8) begin
                  names.push_back(name);
                  exp_data.push_back(ed);
                  exp_err.push_back(ee);
               end
            end
         end
         $fclose(fd);
      end
   end

   task automatic check_response(input data_t data, input logic err);
      int idx;
      idx = done_cnt;
      if (idx >= names.size()) begin
         $display("unexpected response after the last test: data=%h err=%b", data, err);
         err_cnt++;
      end else if (err !== exp_err[idx] || (!exp_err[idx] && data !== exp_data[idx])) begin
         $display("MISMATCH %s: expected data=%h err=%b, actual data=%h err=%b",
                  names[idx], exp_data[idx], exp_err[idx], data, err);
         err_cnt++;
      end else begin
         $display("ok %s: data=%h err=%b", names[idx], data, err);
      end
      done_cnt++;
   endtask

   // Sample shortly before the rising edge where the response is taken
   always @(negedge clk) begin
      #40;
      if (rst_n && rsp_valid && rsp_ready) begin
         check_response(rsp_data, rsp_err);
      end
   end

endmodule

// ==== tb_msr_unit.sv ====
//****************************************
// MSR unit testbench, golden-file driven
//****************************************
`timescale 1ns/1ps

module tb_msr_unit;
   import msr_pkg::*;

   localparam int MAX_WAIT = 200;

   logic      clk = 1'b0;
   logic      rst_n = 1'b0;
   logic      req_valid = 1'b0;
   logic      req_ready;
   msr_op_t   req_op = OP_READ;
   msr_addr_t req_addr = '0;
   data_t     req_wdata = '0;
   data_t     req_pc = '0;
   data_t     req_lsa = '0;
   logic      rsp_valid;
   logic      rsp_ready = 1'b0;
   data_t     rsp_data;
   logic      rsp_err;
   logic [31:0] seed = 32'habc3;
   logic      failed = 1'b0;
   int        n_done;
   int        n_err;

   msr_op_t   q_op[$];
   msr_addr_t q_addr[$];
   data_t     q_wdata[$];
   data_t     q_pc[$];
   data_t     q_lsa[$];

   msr_unit #(
      .CORE_ID (3)
   ) i_msr_unit (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_op    (req_op),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .req_pc    (req_pc),
      .req_lsa   (req_lsa),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data),
      .rsp_err   (rsp_err)
   );

   msr_checker i_checker (
      .clk       (clk),
      .rst_n     (rst_n),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data),
      .rsp_err   (rsp_err),
      .n_done    (n_done),
      .n_err     (n_err)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Response side stalls about one cycle in four
   always @(negedge clk) begin
      seed = lcg_next(seed);
      rsp_ready = (seed[17:16] != 2'b00);
   end

   task automatic load_stimulus();
      int        fd;
      int        cnt;
      string     line;
      string     name;
      msr_op_t   op;
      msr_addr_t addr;
      data_t     wdata, pc, lsa, ed;
      logic      ee;
      fd = $fopen("msr_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open msr_golden.txt");
         failed = 1'b1;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         cnt = $fgets(line, fd);
         if (cnt > 0 && line.getc(0) != "#") begin
            cnt = $sscanf(line, "%s %h %h %h %h %h %h %h",
                          name, op, addr, wdata, pc, lsa, ed, ee);
            if (cnt == 8) begin
               q_op.push_back(op);
               q_addr.push_back(addr);
               q_wdata.push_back(wdata);
               q_pc.push_back(pc);
               q_lsa.push_back(lsa);
            end
         end
      end
      $fclose(fd);
   endtask

   // Called just after a falling edge, returns just after the next one
   // following the accepting rising edge
   task automatic send_request(input msr_op_t op, input msr_addr_t addr,
                               input data_t wdata, input data_t pc,
                               input data_t lsa, output logic ok);
      int   tries;
      logic seen;
      req_valid = 1'b1;
      req_op    = op;
      req_addr  = addr;
      req_wdata = wdata;
      req_pc    = pc;
      req_lsa   = lsa;
      seen  = 1'b0;
      tries = 0;
      while (!seen && tries < MAX_WAIT) begin
         #20;
         seen = req_ready;
         @(negedge clk);
         tries++;
      end
      ok = seen;
   endtask

   initial begin : main
      int   tries;
      int   n_tests;
      logic ok;
      load_stimulus();
      n_tests = q_op.size();
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      for (int i = 0; i < n_tests && !failed; i++) begin
         send_request(q_op[i], q_addr[i], q_wdata[i], q_pc[i], q_lsa[i], ok);
         if (!ok) begin
            $display("request %0d was never accepted, req_ready stayed low", i);
            failed = 1'b1;
         end
      end
      req_valid = 1'b0;
      tries = 0;
      while (n_done < n_tests && tries < MAX_WAIT) begin
         @(negedge clk);
         tries++;
      end
      if (n_done < n_tests) begin
         $display("response timeout: only %0d of %0d responses arrived", n_done, n_tests);
         failed = 1'b1;
      end
      $display("tests: %0d expected, %0d checked, %0d failed", n_tests, n_done, n_err);
      if (failed || n_err != 0 || n_tests == 0) begin
         $display(">>> FAIL");
      end else begin
         $display(">>> PASS");
      end
      $finish;
   end

endmodule

// ==== msr_golden.txt ====
# name op addr wdata pc lsa exp_data exp_err (all hex)
# exp_data is not compared when exp_err is 1
rd_psr_rst   0 0 00000000 00000000 00000000 00000010 0
rd_cpuid     0 1 00000000 00000000 00000000 03040001 0
rd_coreid    0 5 00000000 00000000 00000000 00000003 0
wr_psr       1 0 000003ff 00000000 00000000 000000f1 0
rd_psr       0 0 00000000 00000000 00000000 000000f1 0
wr_epsr      1 2 0000015a 00000000 00000000 0000015a 0
rd_epsr      0 2 00000000 00000000 00000000 0000015a 0
wr_epc       1 3 deadbeef 00000000 00000000 deadbeef 0
rd_epc       0 3 00000000 00000000 00000000 deadbeef 0
wr_elsa      1 4 12345678 00000000 00000000 12345678 0
rd_elsa      0 4 00000000 00000000 00000000 12345678 0
wr_cpuid     1 1 ffffffff 00000000 00000000 00000000 1
rd_cpuid2    0 1 00000000 00000000 00000000 03040001 0
wr_coreid    1 5 ffffffff 00000000 00000000 00000000 1
rd_coreid2   0 5 00000000 00000000 00000000 00000003 0
rd_addr6     0 6 00000000 00000000 00000000 00000000 1
wr_addr7     1 7 00000001 00000000 00000000 00000000 1
rd_psr_chk   0 0 00000000 00000000 00000000 000000f1 0
exc_enter    2 0 00000000 00001000 00002000 00000011 0
rd_epsr2     0 2 00000000 00000000 00000000 000000f1 0
rd_epc2      0 3 00000000 00000000 00000000 00001000 0
rd_elsa2     0 4 00000000 00000000 00000000 00002000 0
rd_psr_hdl   0 0 00000000 00000000 00000000 00000011 0
exc_ret      3 0 00000000 00000000 00000000 00001000 0
rd_psr_ret   0 0 00000000 00000000 00000000 000000f1 0
exc_ret2     3 0 00000000 00000000 00000000 00000000 1
wr_psr2      1 0 00000000 00000000 00000000 00000000 0
exc_enter2   2 0 00000000 aaaa0000 5555aaaa 00000010 0
rd_epsr3     0 2 00000000 00000000 00000000 00000000 0
exc_ret3     3 0 00000000 00000000 00000000 aaaa0000 0
rd_psr_end   0 0 00000000 00000000 00000000 00000000 0

// ==== all.f ====
msr_pkg.sv
msr_req_if.sv
msr_decode.sv
msr_bank.sv
msr_result.sv
msr_unit.sv
msr_checker.sv
tb_msr_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_msr_unit -o sim_msr
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_msr)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q '^>>> PASS$'; then
   exit 0
fi
exit 1
